/* decodePipe.f */
+incdir+include
source/isaPkg.sv
source/ctrlPkg.sv
source/opClassify.sv
source/ctrlGen.sv
source/hazardTiming.sv
source/decodePipe.sv
dv/decodePipeTb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decodePipeTb -f decodePipe.f -o decodePipeSim
./obj_dir/decodePipeSim > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
	exit 0
fi
exit 1

/* include/decodeTable.svh */
`ifndef DECODE_TABLE_SVH
`define DECODE_TABLE_SVH

// ctrl bits: regDest jump jumpReg branch cond memRead memWrite size signLoad
//            aluSrc1 aluSrc2 signExtend regWrite linkWrite aluOp
// hazard bits: rsNeed rtNeed ready rsIdx rtIdx destIdx; excBits are decode bits only
typedef struct packed {
	logic [31:0]          instr;
	ctrlPkg::ctrlWord_t   ctrl;
	ctrlPkg::hazardInfo_t hazard;
	ctrlPkg::excVec_t     excBits;
} decodeEntry_t;

localparam int DECODE_TABLE_LEN = 30;

localparam decodeEntry_t DECODE_TABLE [DECODE_TABLE_LEN] = '{
	'{32'h012a4020, 22'b1_0_0_0_000_0_0_00_0_1_1_0_1_0_00000, 21'b01_01_10_01001_01010_01000, 9'h000},
	'{32'h012a4022, 22'b1_0_0_0_000_0_0_00_0_1_1_0_1_0_00010, 21'b01_01_10_01001_01010_01000, 9'h000},
	'{32'h012a402b, 22'b1_0_0_0_000_0_0_00_0_1_1_0_1_0_00101, 21'b01_01_10_01001_01010_01000, 9'h000},
	'{32'h012a4027, 22'b1_0_0_0_000_0_0_00_0_1_1_0_1_0_01100, 21'b01_01_10_01001_01010_01000, 9'h000},
	'{32'h000a4100, 22'b1_0_0_0_000_0_0_00_0_0_1_0_1_0_10000, 21'b11_01_10_00000_01010_01000, 9'h000},
	'{32'h012a4007, 22'b1_0_0_0_000_0_0_00_0_1_1_0_1_0_10001, 21'b01_01_10_01001_01010_01000, 9'h000},
	'{32'h212affff, 22'b0_0_0_0_000_0_0_00_0_1_0_1_1_0_00000, 21'b01_11_10_01001_01010_01010, 9'h000},
	'{32'h2d2a0010, 22'b0_0_0_0_000_0_0_00_0_1_0_1_1_0_00101, 21'b01_11_10_01001_01010_01010, 9'h000},
	'{32'h352a00ff, 22'b0_0_0_0_000_0_0_00_0_1_0_0_1_0_01101, 21'b01_11_10_01001_01010_01010, 9'h000},
	'{32'h3c0a1234, 22'b0_0_0_0_000_0_0_00_0_1_0_0_1_0_01011, 21'b11_11_10_00000_01010_01010, 9'h000},
	'{32'h112a0004, 22'b0_0_0_1_000_0_0_00_0_1_0_0_0_0_00000, 21'b00_00_01_01001_01010_00000, 9'h000},
	'{32'h152a0004, 22'b0_0_0_1_001_0_0_00_0_1_0_0_0_0_00000, 21'b00_00_01_01001_01010_00000, 9'h000},
	'{32'h1d200004, 22'b0_0_0_1_011_0_0_00_0_1_0_0_0_0_00000, 21'b00_11_01_01001_00000_00000, 9'h000},
	'{32'h05200004, 22'b0_0_0_1_101_0_0_00_0_1_0_0_0_0_00000, 21'b00_11_01_01001_00000_00000, 9'h000},
	'{32'h05310004, 22'b1_0_0_1_110_0_0_00_0_1_0_0_1_1_00000, 21'b00_11_01_01001_10001_11111, 9'h000},
	'{32'h05300004, 22'b1_0_0_1_111_0_0_00_0_1_0_0_1_1_00000, 21'b00_11_01_01001_10000_11111, 9'h000},
	'{32'h08000010, 22'b0_1_0_0_000_0_0_00_0_1_0_0_0_0_00000, 21'b11_11_01_00000_00000_00000, 9'h000},
	'{32'h0c000010, 22'b1_1_0_0_000_0_0_00_0_1_0_0_1_1_00000, 21'b11_11_01_00000_00000_11111, 9'h000},
	'{32'h01200008, 22'b0_1_1_0_000_0_0_00_0_1_0_0_0_0_00000, 21'b00_11_01_01001_00000_00000, 9'h000},
	'{32'h01204009, 22'b1_1_1_0_000_0_0_00_0_1_0_0_1_1_00000, 21'b00_11_01_01001_00000_11111, 9'h000},
	'{32'h812a0004, 22'b0_0_0_0_000_1_0_11_1_1_0_1_1_0_00001, 21'b01_11_11_01001_01010_01010, 9'h000},
	'{32'h952a0004, 22'b0_0_0_0_000_1_0_10_0_1_0_1_1_0_00001, 21'b01_11_11_01001_01010_01010, 9'h000},
	'{32'h8d2a0004, 22'b0_0_0_0_000_1_0_01_0_1_0_1_1_0_00001, 21'b01_11_11_01001_01010_01010, 9'h000},
	'{32'ha12a0004, 22'b0_0_0_0_000_0_1_11_0_1_0_1_0_0_00001, 21'b01_10_01_01001_01010_00000, 9'h000},
	'{32'had2a0004, 22'b0_0_0_0_000_0_1_01_0_1_0_1_0_0_00001, 21'b01_10_01_01001_01010_00000, 9'h000},
	'{32'h0000000d, 22'b0, 21'b11_11_00_00000_00000_00000, 9'h100},
	'{32'h0000000c, 22'b0, 21'b11_11_00_00000_00000_00000, 9'h008},
	'{32'hfc000000, 22'b0, 21'b11_11_00_00000_00000_00000, 9'h040},
	'{32'h012a0018, 22'b0, 21'b11_11_00_01001_01010_00000, 9'h040},
	'{32'h05220004, 22'b0, 21'b11_11_00_01001_00010_00000, 9'h040}
};

`endif

/* dv/decodePipeTb.sv */
`timescale 1ns/1ps
module decodePipeTb;
	import isaPkg::*;
	import ctrlPkg::*;

`include "decodeTable.svh"

	localparam int RESET_CYCLES = 10;
	localparam int LATENCY      = 3;
	localparam int IDLE_AT      = 16; // gap inserted before this entry
	localparam int IDLE_CYCLES  = 3;
	localparam int TAIL_CYCLES  = 5;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + DECODE_TABLE_LEN + LATENCY + 20
		+ IDLE_CYCLES + TAIL_CYCLES;

	typedef struct packed {
		int          index;
		logic [31:0] instr;
		ctrlWord_t   ctrl;
		hazardInfo_t hazard;
		excVec_t     except;
		int          dueCycle;
	} expected_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        inValid;
	logic [31:0] instr;
	excVec_t     ifExcept;
	logic        outValid;
	ctrlWord_t   ctrl;
	hazardInfo_t hazard;
	excVec_t     except;

	expected_t expQ[$];
	expected_t head;
	int        cycle = 0;
	int        errorCount = 0;
	int        passCount = 0;
	int        doneCount = 0;
	bit        entryOk;

	decodePipe i_decodePipe (
		.clk, .rst, .inValid, .instr, .ifExcept,
		.outValid, .ctrl, .hazard, .except
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d entries never came out", cycle, expQ.size());
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic checkCtrl(input ctrlWord_t expVal, input ctrlWord_t actVal, inout bit ok);
		if (actVal !== expVal)
		begin
			$display("ERROR %0d ns ctrl expected %h actual %h", $time, expVal, actVal);
			errorCount++;
			ok = 1'b0;
		end
	endtask

	task automatic checkHazard(input hazardInfo_t expVal, input hazardInfo_t actVal, inout bit ok);
		if (actVal !== expVal)
		begin
			$display("ERROR %0d ns hazard expected %h actual %h", $time, expVal, actVal);
			errorCount++;
			ok = 1'b0;
		end
	endtask

	task automatic checkExcept(input excVec_t expVal, input excVec_t actVal, inout bit ok);
		if (actVal !== expVal)
		begin
			$display("ERROR %0d ns except expected %h actual %h", $time, expVal, actVal);
			errorCount++;
			ok = 1'b0;
		end
	endtask

	task automatic finishEntry(input expected_t item, input bit ok);
		$display("entry %0d instr %h %s", item.index, item.instr, ok ? "ok" : "mismatch");
		if (ok)
			passCount++;
		doneCount++;
	endtask

	// outputs sampled mid-cycle, away from the edge
	always @(negedge clk)
	begin
		if (cycle > 0 && outValid === 1'b1)
		begin
			if (expQ.size() == 0)
			begin
				$display("outValid went high at cycle %0d with nothing in flight", cycle);
				errorCount++;
			end
			else
			begin
				head = expQ.pop_front();
				entryOk = 1'b1;
				if (head.dueCycle != cycle)
				begin
					$display("entry %0d came out at cycle %0d instead of %0d",
						head.index, cycle, head.dueCycle);
					errorCount++;
					entryOk = 1'b0;
				end
				checkCtrl(head.ctrl, ctrl, entryOk);
				checkHazard(head.hazard, hazard, entryOk);
				checkExcept(head.except, except, entryOk);
				finishEntry(head, entryOk);
			end
		end
		else if (cycle > 0)
		begin
			entryOk = 1'b1;
			if (outValid !== 1'b0)
			begin
				$display("outValid unknown at cycle %0d", cycle);
				errorCount++;
			end
			checkCtrl('0, ctrl, entryOk); // idle outputs stay zero
			checkHazard('0, hazard, entryOk);
			checkExcept('0, except, entryOk);
			if (expQ.size() > 0 && expQ[0].dueCycle <= cycle)
			begin
				head = expQ.pop_front();
				$display("entry %0d missing, outValid low at cycle %0d", head.index, cycle);
				errorCount++;
				finishEntry(head, 1'b0);
			end
		end
	end

	initial
	begin
		int        idx;
		logic [31:0] randWord;
		excVec_t   keepMask;
		expected_t item;

		rst      = 1'b1;
		inValid  = 1'b0;
		instr    = '0;
		ifExcept = '0;
		void'($urandom(16));
		keepMask = '1;
		keepMask[EXC_BREAK]    = 1'b0;
		keepMask[EXC_SYSCALL]  = 1'b0;
		keepMask[EXC_RESERVED] = 1'b0;

		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;

		for (idx = 0; idx < DECODE_TABLE_LEN; idx++)
		begin
			if (idx == IDLE_AT)
			begin
				repeat (IDLE_CYCLES)
				begin
					@(posedge clk);
					#1 inValid = 1'b0;
				end
			end
			@(posedge clk);
			#1;
			randWord = $urandom();
			inValid  = 1'b1;
			instr    = DECODE_TABLE[idx].instr;
			ifExcept = randWord[8:0] & keepMask;
			item.index    = idx;
			item.instr    = DECODE_TABLE[idx].instr;
			item.ctrl     = DECODE_TABLE[idx].ctrl;
			item.hazard   = DECODE_TABLE[idx].hazard;
			item.except   = ifExcept | DECODE_TABLE[idx].excBits;
			item.dueCycle = cycle + LATENCY; // seen at the negedge three edges on
			expQ.push_back(item);
		end
		@(posedge clk);
		#1 inValid = 1'b0;
		instr = '0;

		wait (doneCount == DECODE_TABLE_LEN);
		repeat (TAIL_CYCLES) @(posedge clk); // outValid must stay low

		$display("%0d entries, %0d passed, %0d errors", doneCount, passCount, errorCount);
		if (errorCount == 0 && passCount == DECODE_TABLE_LEN)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* source/decodePipe.sv */
`timescale 1ns/1ps
module decodePipe (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 inValid,
	input  logic [31:0]          instr,
	input  ctrlPkg::excVec_t     ifExcept,
	output logic                 outValid,
	output ctrlPkg::ctrlWord_t   ctrl,
	output ctrlPkg::hazardInfo_t hazard,
	output ctrlPkg::excVec_t     except
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic         s1Valid, s2Valid;
	instrKind_t   s1Kind, s2Kind;
	instrFields_t s1Fields, s2Fields;
	excVec_t      s1Except, s2Except;
	ctrlWord_t    s2Ctrl;

	opClassify i_opClassify (
		.clk, .rst, .inValid, .instr, .ifExcept,
		.s1Valid, .s1Kind, .s1Fields, .s1Except
	);

	ctrlGen i_ctrlGen (
		.clk, .rst, .s1Valid, .s1Kind, .s1Fields, .s1Except,
		.s2Valid, .s2Kind, .s2Fields, .s2Ctrl, .s2Except
	);

	hazardTiming i_hazardTiming (
		.clk, .rst, .s2Valid, .s2Kind, .s2Fields, .s2Ctrl, .s2Except,
		.outValid, .ctrl, .hazard, .except
	);

endmodule

/* source/hazardTiming.sv */
`timescale 1ns/1ps
module hazardTiming (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 s2Valid,
	input  isaPkg::instrKind_t   s2Kind,
	input  isaPkg::instrFields_t s2Fields,
	input  ctrlPkg::ctrlWord_t   s2Ctrl,
	input  ctrlPkg::excVec_t     s2Except,
	output logic                 outValid,
	output ctrlPkg::ctrlWord_t   ctrl,
	output ctrlPkg::hazardInfo_t hazard,
	output ctrlPkg::excVec_t     except
);
	import isaPkg::*;
	import ctrlPkg::*;

	hazardInfo_t hazNext;

	always_comb
	begin
		hazNext.rsNeed      = T_EXEC; // register ALU default
		hazNext.rtNeed      = T_EXEC;
		hazNext.resultReady = T_MEM;
		hazNext.rsIdx       = s2Fields.rs;
		hazNext.rtIdx       = s2Fields.rt;
		case (s2Kind)
			KIND_SLL, KIND_SRL, KIND_SRA: hazNext.rsNeed = T_NEVER;
			KIND_ADDI, KIND_ADDIU, KIND_SLTI, KIND_SLTIU, KIND_ANDI, KIND_ORI, KIND_XORI:
				hazNext.rtNeed = T_NEVER;
			KIND_LUI:
			begin
				hazNext.rsNeed = T_NEVER;
				hazNext.rtNeed = T_NEVER;
			end
			KIND_BEQ, KIND_BNE:
			begin
				hazNext.rsNeed      = T_DECODE;
				hazNext.rtNeed      = T_DECODE;
				hazNext.resultReady = T_EXEC;
			end
			KIND_BGEZ, KIND_BGTZ, KIND_BLEZ, KIND_BLTZ, KIND_BGEZAL, KIND_BLTZAL,
			KIND_JR, KIND_JALR:
			begin
				hazNext.rsNeed      = T_DECODE; // compared or jumped to in decode
				hazNext.rtNeed      = T_NEVER;
				hazNext.resultReady = T_EXEC;
			end
			KIND_J, KIND_JAL:
			begin
				hazNext.rsNeed      = T_NEVER;
				hazNext.rtNeed      = T_NEVER;
				hazNext.resultReady = T_EXEC;
			end
			KIND_LB, KIND_LBU, KIND_LH, KIND_LHU, KIND_LW:
			begin
				hazNext.rtNeed      = T_NEVER;
				hazNext.resultReady = 2'd3; // data back after memory
			end
			KIND_SB, KIND_SH, KIND_SW:
			begin
				hazNext.rtNeed      = T_MEM; // store data late
				hazNext.resultReady = T_EXEC;
			end
			KIND_BREAK, KIND_SYSCALL, KIND_RESERVED:
			begin
				hazNext.rsNeed      = T_NEVER;
				hazNext.rtNeed      = T_NEVER;
				hazNext.resultReady = 2'd0;
			end
			default: ;
		endcase

		if (!s2Ctrl.regWrite)
			hazNext.destIdx = 5'd0;
		else if (s2Ctrl.linkWrite)
			hazNext.destIdx = REG_LINK;
		else if (s2Ctrl.regDest)
			hazNext.destIdx = s2Fields.rd;
		else
			hazNext.destIdx = s2Fields.rt;
	end

	always_ff @(posedge clk)
	begin
		outValid <= s2Valid && !rst;
		if (rst || !s2Valid)
		begin
			ctrl   <= '0;
			hazard <= '0;
			except <= '0;
		end
		else
		begin
			ctrl   <= s2Ctrl;
			hazard <= hazNext;
			except <= s2Except;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(hazard.destIdx != 5'd0) |-> ctrl.regWrite);

endmodule

/* source/ctrlGen.sv */
`timescale 1ns/1ps
module ctrlGen (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 s1Valid,
	input  isaPkg::instrKind_t   s1Kind,
	input  isaPkg::instrFields_t s1Fields,
	input  ctrlPkg::excVec_t     s1Except,
	output logic                 s2Valid,
	output isaPkg::instrKind_t   s2Kind,
	output isaPkg::instrFields_t s2Fields,
	output ctrlPkg::ctrlWord_t   s2Ctrl,
	output ctrlPkg::excVec_t     s2Except
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlWord_t ctrlNext;
	excVec_t   excNext;

	always_comb
	begin
		ctrlNext = '0;
		ctrlNext.aluSrc1 = 1'b1; // rs feeds the ALU for nearly everything
		excNext = s1Except;
		case (s1Kind)
			KIND_ADD, KIND_ADDU, KIND_SUB, KIND_SUBU, KIND_SLT, KIND_SLTU, KIND_AND,
			KIND_OR, KIND_XOR, KIND_NOR, KIND_SLLV, KIND_SRLV, KIND_SRAV:
			begin
				ctrlNext.regDest  = 1'b1;
				ctrlNext.aluSrc2  = 1'b1;
				ctrlNext.regWrite = 1'b1;
			end
			KIND_SLL, KIND_SRL, KIND_SRA:
			begin
				ctrlNext.regDest  = 1'b1;
				ctrlNext.aluSrc1  = 1'b0; // shamt instead of rs
				ctrlNext.aluSrc2  = 1'b1;
				ctrlNext.regWrite = 1'b1;
			end
			KIND_ADDI, KIND_ADDIU, KIND_SLTI, KIND_SLTIU:
			begin
				ctrlNext.signExtend = 1'b1;
				ctrlNext.regWrite   = 1'b1;
			end
			KIND_ANDI, KIND_ORI, KIND_XORI, KIND_LUI: ctrlNext.regWrite = 1'b1;
			KIND_LB, KIND_LBU, KIND_LH, KIND_LHU, KIND_LW:
			begin
				ctrlNext.memRead    = 1'b1;
				ctrlNext.signExtend = 1'b1;
				ctrlNext.regWrite   = 1'b1;
				ctrlNext.aluOp      = ALU_ADDU;
			end
			KIND_SB, KIND_SH, KIND_SW:
			begin
				ctrlNext.memWrite   = 1'b1;
				ctrlNext.signExtend = 1'b1;
				ctrlNext.aluOp      = ALU_ADDU;
			end
			KIND_BEQ, KIND_BNE, KIND_BGEZ, KIND_BGTZ, KIND_BLEZ, KIND_BLTZ:
				ctrlNext.branch = 1'b1;
			KIND_BGEZAL, KIND_BLTZAL, KIND_JAL, KIND_JALR:
			begin
				ctrlNext.regDest   = 1'b1;
				ctrlNext.regWrite  = 1'b1;
				ctrlNext.linkWrite = 1'b1;
			end
			KIND_J, KIND_JR: ; // jump bits set below
			default:      ctrlNext = '0; // exception kinds carry no control
		endcase

		case (s1Kind)
			KIND_ADDU, KIND_ADDIU: ctrlNext.aluOp = ALU_ADDU;
			KIND_SUB:              ctrlNext.aluOp = ALU_SUB;
			KIND_SUBU:             ctrlNext.aluOp = ALU_SUBU;
			KIND_SLT, KIND_SLTI:   ctrlNext.aluOp = ALU_SLT;
			KIND_SLTU, KIND_SLTIU: ctrlNext.aluOp = ALU_SLTU;
			KIND_AND, KIND_ANDI:   ctrlNext.aluOp = ALU_AND;
			KIND_OR, KIND_ORI:     ctrlNext.aluOp = ALU_OR;
			KIND_XOR, KIND_XORI:   ctrlNext.aluOp = ALU_XOR;
			KIND_NOR:              ctrlNext.aluOp = ALU_NOR;
			KIND_LUI:              ctrlNext.aluOp = ALU_LUI;
			KIND_SLL:              ctrlNext.aluOp = ALU_SLL;
			KIND_SRL:              ctrlNext.aluOp = ALU_SRL;
			KIND_SRA:              ctrlNext.aluOp = ALU_SRA;
			KIND_SLLV:             ctrlNext.aluOp = ALU_SLLV;
			KIND_SRLV:             ctrlNext.aluOp = ALU_SRLV;
			KIND_SRAV:             ctrlNext.aluOp = ALU_SRAV;
			KIND_BNE:              ctrlNext.branchCond = BR_NE;
			KIND_BGEZ:             ctrlNext.branchCond = BR_GEZ;
			KIND_BGTZ:             ctrlNext.branchCond = BR_GTZ;
			KIND_BLEZ:             ctrlNext.branchCond = BR_LEZ;
			KIND_BLTZ:             ctrlNext.branchCond = BR_LTZ;
			KIND_BGEZAL:
			begin
				ctrlNext.branch     = 1'b1;
				ctrlNext.branchCond = BR_GEZAL;
			end
			KIND_BLTZAL:
			begin
				ctrlNext.branch     = 1'b1;
				ctrlNext.branchCond = BR_LTZAL;
			end
			KIND_J, KIND_JAL:      ctrlNext.jump = 1'b1;
			KIND_JR, KIND_JALR:
			begin
				ctrlNext.jump    = 1'b1;
				ctrlNext.jumpReg = 1'b1;
			end
			KIND_LB:
			begin
				ctrlNext.memSize  = SIZE_BYTE;
				ctrlNext.signLoad = 1'b1;
			end
			KIND_LH:
			begin
				ctrlNext.memSize  = SIZE_HALF;
				ctrlNext.signLoad = 1'b1;
			end
			KIND_LBU, KIND_SB:     ctrlNext.memSize = SIZE_BYTE;
			KIND_LHU, KIND_SH:     ctrlNext.memSize = SIZE_HALF;
			KIND_LW, KIND_SW:      ctrlNext.memSize = SIZE_WORD;
			KIND_BREAK:            excNext[EXC_BREAK] = 1'b1;
			KIND_SYSCALL:          excNext[EXC_SYSCALL] = 1'b1;
			KIND_RESERVED:         excNext[EXC_RESERVED] = 1'b1;
			default:               ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		s2Valid <= s1Valid && !rst;
		if (rst || !s1Valid)
		begin
			s2Kind   <= instrKind_t'('0);
			s2Fields <= '0;
			s2Ctrl   <= '0;
			s2Except <= '0;
		end
		else
		begin
			s2Kind   <= s1Kind;
			s2Fields <= s1Fields;
			s2Ctrl   <= ctrlNext;
			s2Except <= excNext;
		end
	end

	// a memory access is either a load or a store
	assert property (@(posedge clk) disable iff (rst)
		s2Valid |-> !(s2Ctrl.memRead && s2Ctrl.memWrite));

endmodule

/* source/opClassify.sv */
`timescale 1ns/1ps
module opClassify (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 inValid,
	input  logic [31:0]          instr,
	input  ctrlPkg::excVec_t     ifExcept,
	output logic                 s1Valid,
	output isaPkg::instrKind_t   s1Kind,
	output isaPkg::instrFields_t s1Fields,
	output ctrlPkg::excVec_t     s1Except
);
	import isaPkg::*;

	instrFields_t fields;
	instrKind_t   kind;

	assign fields = instrFields_t'(instr);

	always_comb
	begin
		kind = KIND_RESERVED; // also covers hi/lo and cop0 encodings
		case (fields.op)
			OP_SPECIAL:
			begin
				case (fields.funct)
					FN_ADD:     kind = KIND_ADD;
					FN_ADDU:    kind = KIND_ADDU;
					FN_SUB:     kind = KIND_SUB;
					FN_SUBU:    kind = KIND_SUBU;
					FN_SLT:     kind = KIND_SLT;
					FN_SLTU:    kind = KIND_SLTU;
					FN_AND:     kind = KIND_AND;
					FN_OR:      kind = KIND_OR;
					FN_XOR:     kind = KIND_XOR;
					FN_NOR:     kind = KIND_NOR;
					FN_SLL:     kind = KIND_SLL;
					FN_SRL:     kind = KIND_SRL;
					FN_SRA:     kind = KIND_SRA;
					FN_SLLV:    kind = KIND_SLLV;
					FN_SRLV:    kind = KIND_SRLV;
					FN_SRAV:    kind = KIND_SRAV;
					FN_JR:      kind = KIND_JR;
					FN_JALR:    kind = KIND_JALR;
					FN_BREAK:   kind = KIND_BREAK;
					FN_SYSCALL: kind = KIND_SYSCALL;
					default:    kind = KIND_RESERVED;
				endcase
			end
			OP_REGIMM:
			begin
				case (fields.rt)
					RT_BLTZ:   kind = KIND_BLTZ;
					RT_BGEZ:   kind = KIND_BGEZ;
					RT_BLTZAL: kind = KIND_BLTZAL;
					RT_BGEZAL: kind = KIND_BGEZAL;
					default:   kind = KIND_RESERVED;
				endcase
			end
			OP_J:     kind = KIND_J;
			OP_JAL:   kind = KIND_JAL;
			OP_BEQ:   kind = KIND_BEQ;
			OP_BNE:   kind = KIND_BNE;
			OP_BLEZ:  kind = KIND_BLEZ;
			OP_BGTZ:  kind = KIND_BGTZ;
			OP_ADDI:  kind = KIND_ADDI;
			OP_ADDIU: kind = KIND_ADDIU;
			OP_SLTI:  kind = KIND_SLTI;
			OP_SLTIU: kind = KIND_SLTIU;
			OP_ANDI:  kind = KIND_ANDI;
			OP_ORI:   kind = KIND_ORI;
			OP_XORI:  kind = KIND_XORI;
			OP_LUI:   kind = KIND_LUI;
			OP_LB:    kind = KIND_LB;
			OP_LH:    kind = KIND_LH;
			OP_LW:    kind = KIND_LW;
			OP_LBU:   kind = KIND_LBU;
			OP_LHU:   kind = KIND_LHU;
			OP_SB:    kind = KIND_SB;
			OP_SH:    kind = KIND_SH;
			OP_SW:    kind = KIND_SW;
			default:  kind = KIND_RESERVED;
		endcase
	end

	always_ff @(posedge clk)
	begin
		s1Valid <= inValid && !rst;
		if (rst || !inValid)
		begin
			s1Kind   <= instrKind_t'('0);
			s1Fields <= '0;
			s1Except <= '0;
		end
		else
		begin
			s1Kind   <= kind;
			s1Fields <= fields;
			s1Except <= ifExcept;
		end
	end

endmodule

/* source/ctrlPkg.sv */
package ctrlPkg;

	typedef enum logic [4:0] {
		ALU_ADD  = 5'd0,
		ALU_ADDU = 5'd1,
		ALU_SUB  = 5'd2,
		ALU_SUBU = 5'd3,
		ALU_SLT  = 5'd4,
		ALU_SLTU = 5'd5,
		ALU_AND  = 5'd10,
		ALU_LUI  = 5'd11,
		ALU_NOR  = 5'd12,
		ALU_OR   = 5'd13,
		ALU_XOR  = 5'd14,
		ALU_SLLV = 5'd15,
		ALU_SLL  = 5'd16,
		ALU_SRAV = 5'd17,
		ALU_SRA  = 5'd18,
		ALU_SRLV = 5'd19,
		ALU_SRL  = 5'd20
	} aluOp_t;

	typedef enum logic [2:0] {
		BR_EQ, BR_NE, BR_GEZ, BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZAL, BR_LTZAL
	} branchCond_t;

	typedef enum logic [1:0] {
		SIZE_NONE, SIZE_WORD, SIZE_HALF, SIZE_BYTE
	} accessSize_t;

	// need: stage where operand is used; ready: stage where result exists, 0 = no result
	typedef logic [1:0] timing_t;
	localparam timing_t T_DECODE = 2'd0;
	localparam timing_t T_EXEC   = 2'd1;
	localparam timing_t T_MEM    = 2'd2;
	localparam timing_t T_NEVER  = 2'd3;

	typedef struct packed {
		logic        regDest;
		logic        jump;
		logic        jumpReg;
		logic        branch;
		branchCond_t branchCond;
		logic        memRead;
		logic        memWrite;
		accessSize_t memSize;
		logic        signLoad;
		logic        aluSrc1;
		logic        aluSrc2;
		logic        signExtend;
		logic        regWrite;
		logic        linkWrite;
		aluOp_t      aluOp;
	} ctrlWord_t;

	typedef struct packed {
		timing_t    rsNeed;
		timing_t    rtNeed;
		timing_t    resultReady;
		logic [4:0] rsIdx;
		logic [4:0] rtIdx;
		logic [4:0] destIdx;
	} hazardInfo_t;

	typedef logic [8:0] excVec_t;

	localparam int EXC_BREAK    = 8;
	localparam int EXC_RESERVED = 6;
	localparam int EXC_SYSCALL  = 3;

endpackage

/* source/isaPkg.sv */
package isaPkg;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_REGIMM  = 6'h01,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_BLEZ    = 6'h06,
		OP_BGTZ    = 6'h07,
		OP_ADDI    = 6'h08,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LB      = 6'h20,
		OP_LH      = 6'h21,
		OP_LW      = 6'h23,
		OP_LBU     = 6'h24,
		OP_LHU     = 6'h25,
		OP_SB      = 6'h28,
		OP_SH      = 6'h29,
		OP_SW      = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_SLLV = 6'h04,
		FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR = 6'h08, FN_JALR = 6'h09,
		FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d, FN_ADD = 6'h20, FN_ADDU = 6'h21,
		FN_SUB = 6'h22, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25,
		FN_XOR = 6'h26, FN_NOR = 6'h27, FN_SLT = 6'h2a, FN_SLTU = 6'h2b
	} funct_t;

	// rt field of the regimm opcode
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	typedef struct packed {
		opcode_t    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t     funct;
	} instrFields_t;

	typedef enum logic [5:0] {
		KIND_ADD, KIND_ADDU, KIND_SUB, KIND_SUBU, KIND_SLT, KIND_SLTU,
		KIND_AND, KIND_OR, KIND_XOR, KIND_NOR,
		KIND_SLL, KIND_SRL, KIND_SRA, KIND_SLLV, KIND_SRLV, KIND_SRAV,
		KIND_ADDI, KIND_ADDIU, KIND_SLTI, KIND_SLTIU, KIND_ANDI, KIND_ORI, KIND_XORI, KIND_LUI,
		KIND_BEQ, KIND_BNE, KIND_BGEZ, KIND_BGTZ, KIND_BLEZ, KIND_BLTZ, KIND_BGEZAL, KIND_BLTZAL,
		KIND_J, KIND_JAL, KIND_JR, KIND_JALR,
		KIND_LB, KIND_LBU, KIND_LH, KIND_LHU, KIND_LW, KIND_SB, KIND_SH, KIND_SW,
		KIND_BREAK, KIND_SYSCALL, KIND_RESERVED
	} instrKind_t;

	localparam logic [4:0] REG_LINK = 5'd31;

endpackage
